// ==== src/mic_cfg.svh ====
`ifndef MIC_CFG_SVH
`define MIC_CFG_SVH

// clk_m cycles per mic clock period, high for the first half
`define MIC_CLK_DIV 8

// mic ticks tallied into one PCM sample
`define MIC_PDM_WINDOW 64

// signed PCM sample width
`define MIC_SAMPLE_W 16

// normalizes the 1,3,3,1 tap sum back to unity gain
`define MIC_FIR_SHIFT 3

`endif

// ==== src/mic_audio_pkg.sv ====
`include "mic_cfg.svh"

package mic_audio_pkg;

  // one audio beat, valid for a single cycle and never stalled
  typedef struct packed {
    logic signed [`MIC_SAMPLE_W-1:0] sample;
    logic                            valid;
  } pcm_beat_t;

  typedef enum logic [1:0] {
    SRC_RAW     = 2'd0,  // straight from the pdm tally
    SRC_HALF    = 2'd1,  // after dec_a
    SRC_QUARTER = 2'd2,  // after dec_b
    SRC_SILENT  = 2'd3
  } audio_src_e;

  typedef enum logic [1:0] {
    SPK_PDM  = 2'd0,  // sigma-delta of the monitor level
    SPK_PASS = 2'd1,  // raw mic bit
    SPK_MUTE = 2'd2
  } spk_mode_e;

  typedef enum logic {
    CTRL_IDLE = 1'b0,
    CTRL_ACK  = 1'b1
  } ctrl_state_e;

  localparam logic [1:0] CFG_SEL_GAIN  = 2'd1;
  localparam logic [1:0] CFG_SEL_ROUTE = 2'd2;

  typedef struct packed {
    logic [1:0]  sel;
    logic [10:0] rsvd;
    logic [2:0]  volume;
  } cfg_gain_t;

  typedef struct packed {
    logic [1:0] sel;
    logic [9:0] rsvd;
    audio_src_e src;
    spk_mode_e  mode;
  } cfg_route_t;

  // selector sits in the top two bits of both views
  typedef union packed {
    cfg_gain_t  gain;
    cfg_route_t route;
  } cfg_word_u;

endpackage

// ==== src/pdm_capture.sv ====
`timescale 1ns/100ps
`include "mic_cfg.svh"

module pdm_capture import mic_audio_pkg::*; (
  input  logic      clk_m,
  input  logic      reset,
  input  logic      mic_data,
  output logic      mic_clk,
  output logic      mic_tick,
  output logic      mic_bit,
  output pcm_beat_t beat
);

  localparam int SW      = `MIC_SAMPLE_W;
  localparam int DIV_W   = $clog2(`MIC_CLK_DIV);
  localparam int WIN_W   = $clog2(`MIC_PDM_WINDOW);
  localparam int TALLY_W = WIN_W + 1;  // must hold a full window of ones

  logic [DIV_W-1:0]   div_cnt;
  logic [WIN_W-1:0]   win_cnt;
  logic [TALLY_W-1:0] tally;
  logic [TALLY_W-1:0] ones;      // tally including the bit arriving now
  logic               win_last;

  assign ones     = tally + TALLY_W'(mic_data);
  assign win_last = (win_cnt == WIN_W'(`MIC_PDM_WINDOW - 1));

  always_ff @(posedge clk_m) begin
    if (reset) begin
      div_cnt  <= '0;
      mic_clk  <= 1'b0;
      mic_tick <= 1'b0;
    end else begin
      div_cnt  <= (div_cnt == DIV_W'(`MIC_CLK_DIV - 1)) ? '0 : div_cnt + 1'b1;
      mic_clk  <= (div_cnt < DIV_W'(`MIC_CLK_DIV / 2));
      mic_tick <= (div_cnt == '0);  // first cycle of the high phase
    end
  end

  always_ff @(posedge clk_m) begin
    if (reset) begin
      win_cnt    <= '0;
      tally      <= '0;
      mic_bit    <= 1'b0;
      beat.valid <= 1'b0;
    end else begin
      beat.valid <= mic_tick && win_last;
      if (mic_tick) begin
        mic_bit <= mic_data;
        win_cnt <= win_last ? '0 : win_cnt + 1'b1;
        tally   <= win_last ? '0 : ones;
        if (win_last) begin
          // centre the count: 2*ones - window
          beat.sample <= (SW'(ones) <<< 1) - SW'(`MIC_PDM_WINDOW);
        end
      end
    end
  end

endmodule

// ==== src/fir_decimator.sv ====
`timescale 1ns/100ps
`include "mic_cfg.svh"

module fir_decimator import mic_audio_pkg::*; (
  input  logic      clk_m,
  input  logic      reset,
  input  pcm_beat_t in_beat,
  output pcm_beat_t out_beat
);

  localparam int SW    = `MIC_SAMPLE_W;
  localparam int SUM_W = SW + 3;  // headroom for a tap weight of 8

  // the arriving sample plus three held ones form the four-tap line
  logic signed [SW-1:0]    hist [3];
  logic                    phase;
  logic signed [SUM_W-1:0] x0;
  logic signed [SUM_W-1:0] x1;
  logic signed [SUM_W-1:0] x2;
  logic signed [SUM_W-1:0] x3;
  logic signed [SUM_W-1:0] sum;
  logic signed [SUM_W-1:0] scaled;

  assign x0 = SUM_W'(in_beat.sample);
  assign x1 = SUM_W'(hist[0]);
  assign x2 = SUM_W'(hist[1]);
  assign x3 = SUM_W'(hist[2]);

  // taps 1,3,3,1
  assign sum    = x0 + (x1 <<< 1) + x1 + (x2 <<< 1) + x2 + x3;
  assign scaled = sum >>> `MIC_FIR_SHIFT;  // floors toward minus infinity

  always_ff @(posedge clk_m) begin
    if (in_beat.valid) begin
      hist[0] <= in_beat.sample;
      hist[1] <= hist[0];
      hist[2] <= hist[1];
    end
  end

  always_ff @(posedge clk_m) begin
    if (reset) begin
      phase          <= 1'b0;
      out_beat.valid <= 1'b0;
    end else begin
      out_beat.valid <= in_beat.valid && phase;
      if (in_beat.valid) begin
        phase <= ~phase;
      end
    end
  end

  // payload only matters when valid goes out
  always_ff @(posedge clk_m) begin
    if (in_beat.valid && phase) begin
      out_beat.sample <= SW'(scaled);
    end
  end

endmodule

// ==== src/audio_ctrl_regs.sv ====
`timescale 1ns/100ps

module audio_ctrl_regs import mic_audio_pkg::*; (
  input  logic       clk_m,
  input  logic       reset,
  input  logic       cfg_req,
  input  cfg_word_u  cfg_word,
  output logic       cfg_ack,
  output logic [2:0] volume,
  output audio_src_e src,
  output spk_mode_e  spk_mode
);

  ctrl_state_e state;

  assign cfg_ack = (state == CTRL_ACK);

  always_ff @(posedge clk_m) begin
    if (reset) begin
      state    <= CTRL_IDLE;
      volume   <= 3'd7;      // full scale
      src      <= SRC_RAW;
      spk_mode <= SPK_MUTE;  // quiet until the host asks
    end else begin
      case (state)
        CTRL_IDLE: begin
          if (cfg_req) begin
            state <= CTRL_ACK;
            // word is stable while req is high
            case (cfg_word.gain.sel)
              CFG_SEL_GAIN: begin
                volume <= cfg_word.gain.volume;
              end
              CFG_SEL_ROUTE: begin
                src      <= cfg_word.route.src;
                spk_mode <= cfg_word.route.mode;
              end
              default: begin
                // other selectors are acked and dropped
              end
            endcase
          end
        end
        CTRL_ACK: begin
          if (!cfg_req) begin
            state <= CTRL_IDLE;  // ack drops next cycle
          end
        end
      endcase
    end
  end

endmodule

// ==== src/audio_out_stage.sv ====
`timescale 1ns/100ps
`include "mic_cfg.svh"

module audio_out_stage import mic_audio_pkg::*; (
  input  logic       clk_m,
  input  logic       reset,
  input  pcm_beat_t  raw,
  input  pcm_beat_t  half,
  input  pcm_beat_t  quarter,
  input  logic [2:0] volume,
  input  audio_src_e src,
  input  spk_mode_e  spk_mode,
  input  logic       mic_tick,
  input  logic       mic_bit,
  output pcm_beat_t  monitor,
  output logic       spk
);

  localparam int SW = `MIC_SAMPLE_W;
  localparam logic signed [SW-1:0] LVL_MAX = 127;
  localparam logic signed [SW-1:0] LVL_MIN = -128;

  pcm_beat_t            sel_beat;
  logic [2:0]           shift;
  logic signed [SW-1:0] scaled;
  logic signed [7:0]    level;
  logic [7:0]           level_u;  // level offset by 128
  logic [7:0]           acc;
  logic                 pdm_bit;

  always_comb begin
    case (src)
      SRC_RAW:     sel_beat = raw;
      SRC_HALF:    sel_beat = half;
      SRC_QUARTER: sel_beat = quarter;
      default:     sel_beat = '{sample: '0, valid: raw.valid};  // zeros at the raw rate
    endcase
  end

  assign shift  = 3'd7 - volume;
  assign scaled = $signed(sel_beat.sample) >>> shift;

  always_ff @(posedge clk_m) begin
    if (reset) begin
      monitor.valid <= 1'b0;
    end else begin
      monitor.valid <= sel_beat.valid;
    end
    if (sel_beat.valid) begin
      monitor.sample <= scaled;  // held until the next beat
    end
  end

  // saturate the held sample to what the modulator can take
  assign level = (monitor.sample > LVL_MAX) ? 8'sd127 :
                 (monitor.sample < LVL_MIN) ? -8'sd128 : monitor.sample[7:0];
  assign level_u = {~level[7], level[6:0]};

  always_ff @(posedge clk_m) begin
    if (reset) begin
      acc     <= '0;
      pdm_bit <= 1'b0;
    end else if (mic_tick) begin
      {pdm_bit, acc} <= {1'b0, acc} + {1'b0, level_u};  // carry out is the density bit
    end
  end

  always_comb begin
    case (spk_mode)
      SPK_PDM:  spk = pdm_bit;
      SPK_PASS: spk = mic_bit;
      default:  spk = 1'b0;
    endcase
  end

endmodule

// ==== src/mic_audio_top.sv ====
`timescale 1ns/100ps

module mic_audio_top import mic_audio_pkg::*; (
  input  logic      clk_m,
  input  logic      reset,
  input  logic      mic_data,
  output logic      mic_clk,
  input  logic      cfg_req,
  input  cfg_word_u cfg_word,
  output logic      cfg_ack,
  output pcm_beat_t monitor,
  output logic      spk
);

  pcm_beat_t  raw_beat;
  pcm_beat_t  half_beat;
  pcm_beat_t  quarter_beat;
  logic       mic_tick;
  logic       mic_bit;
  logic [2:0] volume;
  audio_src_e src;
  spk_mode_e  spk_mode;

  pdm_capture capture (
    .clk_m    (clk_m),
    .reset    (reset),
    .mic_data (mic_data),
    .mic_clk  (mic_clk),
    .mic_tick (mic_tick),
    .mic_bit  (mic_bit),
    .beat     (raw_beat)
  );

  fir_decimator dec_a (
    .clk_m    (clk_m),
    .reset    (reset),
    .in_beat  (raw_beat),
    .out_beat (half_beat)
  );

  fir_decimator dec_b (
    .clk_m    (clk_m),
    .reset    (reset),
    .in_beat  (half_beat),
    .out_beat (quarter_beat)
  );

  audio_ctrl_regs regs (
    .clk_m    (clk_m),
    .reset    (reset),
    .cfg_req  (cfg_req),
    .cfg_word (cfg_word),
    .cfg_ack  (cfg_ack),
    .volume   (volume),
    .src      (src),
    .spk_mode (spk_mode)
  );

  audio_out_stage out_stage (
    .clk_m    (clk_m),
    .reset    (reset),
    .raw      (raw_beat),
    .half     (half_beat),
    .quarter  (quarter_beat),
    .volume   (volume),
    .src      (src),
    .spk_mode (spk_mode),
    .mic_tick (mic_tick),
    .mic_bit  (mic_bit),
    .monitor  (monitor),
    .spk      (spk)
  );

endmodule

// ==== bench/mic_audio_properties.sv ====
`timescale 1ns/100ps

module mic_audio_properties (
  input logic clk_m,
  input logic reset,
  input logic cfg_req,
  input logic cfg_ack
);

  // the host holds req until it has seen ack
  ack_rise_with_req: assert property (
    @(posedge clk_m) disable iff (reset) $rose(cfg_ack) |-> cfg_req
  ) else $error("cfg_ack rose while cfg_req was low");

  ack_fall_after_req: assert property (
    @(posedge clk_m) disable iff (reset) $fell(cfg_ack) |-> !$past(cfg_req)
  ) else $error("cfg_ack fell before cfg_req was dropped");

  ack_low_after_reset: assert property (
    @(posedge clk_m) reset |=> !cfg_ack
  ) else $error("cfg_ack high in the cycle after reset");

endmodule

bind audio_ctrl_regs mic_audio_properties props (
  .clk_m   (clk_m),
  .reset   (reset),
  .cfg_req (cfg_req),
  .cfg_ack (cfg_ack)
);

// ==== bench/mic_audio_tb.sv ====
`timescale 1ns/100ps
`include "mic_cfg.svh"

module mic_audio_tb import mic_audio_pkg::*; ();

  localparam int BEAT_GAP = `MIC_PDM_WINDOW * `MIC_CLK_DIV;

  logic        clk_m = 1'b0;
  logic        reset;
  logic        mic_data;
  logic        mic_clk;
  logic        cfg_req;
  cfg_word_u   cfg_word;
  logic        cfg_ack;
  pcm_beat_t   monitor;
  logic        spk;
  logic        mic_clk_q;
  logic        tick;
  logic [1:0]  pattern;    // 0 ones, 1 zeros, 2 alternating, 3 random word per window
  logic [63:0] rand_word;
  logic [5:0]  tick_idx;
  logic        done;

  mic_audio_top dut (.*);

  always #4 clk_m = ~clk_m;

  assign tick = mic_clk && !mic_clk_q;  // the DUT samples mic_data on this edge

  // mic model sets up the next bit on the tick edge
  always @(posedge clk_m) begin
    mic_clk_q <= mic_clk;
    if (tick) begin
      tick_idx <= tick_idx + 6'd1;
      case (pattern)
        2'd0:    mic_data <= 1'b1;
        2'd1:    mic_data <= 1'b0;
        2'd2:    mic_data <= ~mic_data;
        default: mic_data <= rand_word[tick_idx + 6'd1];
      endcase
    end
  end

  task automatic abort_run(input string msg);
    done = 1'b1;
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic expect_eq(input int got, input int exp, input string what);
    assert (got == exp) else
      abort_run($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp));
  endtask

  function automatic int window_sample(input int ones);
    return 2 * ones - `MIC_PDM_WINDOW;
  endfunction

  function automatic int shift_volume(input int s, input int vol);
    return s >>> (7 - vol);
  endfunction

  function automatic int clamp_level(input int s);
    if (s > 127)
      return 127;
    if (s < -128)
      return -128;
    return s;
  endfunction

  function automatic cfg_word_u gain_word(input logic [2:0] vol);
    cfg_word_u w;
    w             = '0;
    w.gain.sel    = CFG_SEL_GAIN;
    w.gain.volume = vol;
    return w;
  endfunction

  function automatic cfg_word_u route_word(input audio_src_e s, input spk_mode_e m);
    cfg_word_u w;
    w            = '0;
    w.route.sel  = CFG_SEL_ROUTE;
    w.route.src  = s;
    w.route.mode = m;
    return w;
  endfunction

  task automatic next_tick(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_m);
      cycles++;
      assert (cycles <= 4 * `MIC_CLK_DIV) else abort_run("mic clock stopped rising");
    end while (!tick);
  endtask

  task automatic wait_beat(output int sample, output int cycles);
    cycles = 0;
    do begin
      @(posedge clk_m);
      cycles++;
      assert (cycles <= 5 * BEAT_GAP) else abort_run("no monitor beat arrived in time");
    end while (!monitor.valid);
    sample = int'(monitor.sample);
  endtask

  // four-phase write with ack seen two edges after req moves
  task automatic cfg_write(input cfg_word_u word);
    int cycles;
    @(posedge clk_m);
    cfg_word <= word;
    cfg_req  <= 1'b1;
    cycles = 0;
    do begin
      @(posedge clk_m);
      cycles++;
      assert (cycles <= 16) else abort_run("cfg_ack never rose");
    end while (!cfg_ack);
    expect_eq(cycles, 2, "cycles until cfg_ack rise");
    cfg_req <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk_m);
      cycles++;
      assert (cycles <= 16) else abort_run("cfg_ack never fell");
    end while (cfg_ack);
    expect_eq(cycles, 2, "cycles until cfg_ack fall");
  endtask

  task automatic count_spk(input int n, output int ones);
    int cycles;
    ones = 0;
    repeat (n) begin
      next_tick(cycles);
      ones += int'(spk);
    end
  endtask

  // skip settling beats and then expect two matching beats one gap apart
  task automatic stream_level(input int exp, input int gap, input int skip, input string what);
    int sample;
    int cycles;
    repeat (skip) wait_beat(sample, cycles);
    wait_beat(sample, cycles);
    expect_eq(sample, exp, what);
    wait_beat(sample, cycles);
    expect_eq(sample, exp, what);
    expect_eq(cycles, gap, {what, " beat spacing"});
  endtask

  task automatic pass_through(input int n);
    int   cycles;
    logic last_bit;
    next_tick(cycles);
    last_bit = mic_data;
    repeat (n) begin
      next_tick(cycles);
      expect_eq(spk, last_bit, "spk in pass-through");
      last_bit = mic_data;
    end
  endtask

  task automatic reset_state();
    int cycles;
    expect_eq(cfg_ack, 0, "cfg_ack after reset");
    expect_eq(monitor.valid, 0, "monitor valid after reset");
    expect_eq(spk, 0, "spk after reset");
    next_tick(cycles);
    repeat (2) begin
      next_tick(cycles);
      expect_eq(cycles, `MIC_CLK_DIV, "mic_clk period");
    end
  endtask

  task automatic raw_capture();
    int ones;
    cfg_write(route_word(SRC_RAW, SPK_MUTE));
    cfg_write(gain_word(3'd7));
    pattern <= 2'd0;
    stream_level(window_sample(64), BEAT_GAP, 1, "raw all ones");
    cfg_write(cfg_word_u'(16'hc000));  // unused selectors change nothing
    cfg_write(cfg_word_u'(16'h0000));
    stream_level(window_sample(64), BEAT_GAP, 0, "raw after unused selector");
    count_spk(16, ones);
    expect_eq(ones, 0, "spk ones after unused selector");
    pattern <= 2'd1;
    stream_level(window_sample(0), BEAT_GAP, 1, "raw all zeros");
    pattern <= 2'd2;
    stream_level(window_sample(32), BEAT_GAP, 1, "raw alternating");
  endtask

  task automatic decimated_sources();
    pattern <= 2'd0;
    cfg_write(route_word(SRC_HALF, SPK_MUTE));
    stream_level(window_sample(64), 2 * BEAT_GAP, 3, "by-two stream");
    cfg_write(route_word(SRC_QUARTER, SPK_MUTE));
    stream_level(window_sample(64), 4 * BEAT_GAP, 3, "by-four stream");
  endtask

  task automatic volume_steps();
    cfg_write(route_word(SRC_RAW, SPK_MUTE));
    cfg_write(gain_word(3'd5));
    stream_level(shift_volume(window_sample(64), 5), BEAT_GAP, 1, "volume 5 ones");
    pattern <= 2'd1;
    stream_level(shift_volume(window_sample(0), 5), BEAT_GAP, 1, "volume 5 zeros");
    cfg_write(gain_word(3'd0));
    stream_level(shift_volume(window_sample(0), 0), BEAT_GAP, 1, "volume 0 zeros");
    pattern <= 2'd0;
    stream_level(shift_volume(window_sample(64), 0), BEAT_GAP, 1, "volume 0 ones");
    cfg_write(gain_word(3'd7));
  endtask

  task automatic speaker_modes();
    int ones;
    int level;
    count_spk(64, ones);
    expect_eq(ones, 0, "spk ones while muted");
    pattern <= 2'd2;
    cfg_write(route_word(SRC_RAW, SPK_PASS));
    pass_through(32);
    rand_word <= {$urandom, $urandom};
    pattern   <= 2'd3;
    cfg_write(route_word(SRC_RAW, SPK_PDM));
    level = clamp_level(shift_volume(window_sample($countones(rand_word)), 7));
    stream_level(level, BEAT_GAP, 1, "raw random word");
    count_spk(256, ones);
    assert (ones >= level + 126 && ones <= level + 130) else
      abort_run($sformatf("Mismatch at %0t: %0d pdm ones for level %0d", $time, ones, level));
  endtask

  initial begin
    void'($urandom(32'h467c_dc93));
    done      = 1'b0;
    reset     = 1'b1;
    mic_data  = 1'b0;
    cfg_req   = 1'b0;
    cfg_word  = '0;
    pattern   = 2'd0;
    rand_word = '0;
    tick_idx  = '0;
    mic_clk_q = 1'b0;
    repeat (5) @(posedge clk_m);
    reset <= 1'b0;
    reset_state();
    raw_capture();
    decimated_sources();
    volume_steps();
    speaker_modes();
    done = 1'b1;
    $display("Result: PASSED");
    $finish;
  end

  final begin
    if (!done)
      $display("Result: FAILED");
  end

endmodule

// ==== flist.f ====
+incdir+src
src/mic_audio_pkg.sv
src/pdm_capture.sv
src/fir_decimator.sv
src/audio_ctrl_regs.sv
src/audio_out_stage.sv
src/mic_audio_top.sv
bench/mic_audio_properties.sv
bench/mic_audio_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f flist.f --top-module mic_audio_tb -o mic_audio_sim \
  && ./obj_dir/mic_audio_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation run ok" \
  || { echo "simulation run failed"; exit 1; }
